// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      = tb_host_rd_bridge
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: burst_split_fsm.sv
// burst splitter for host reads
// cuts one AFU burst into page-safe TLP reads no larger than the maximum payload
`timescale 1ns/1ns
`default_nettype none

module burst_split_fsm
(
    input  logic                            afu_clk,
    input  logic                            rst,

    // AFU request side
    input  logic                            rd_read,
    input  hc_pkg::rd_req_t                 rd_req,
    output logic                            rd_waitrequest,

    // credit handshake with the ROB index counter
    input  logic                            alloc_ok,
    input  logic [hc_pkg::ROB_IDX_W-1:0]    alloc_idx,
    output logic [hc_pkg::LEN_W-1:0]        alloc_len,
    output logic                            alloc,

    // host request side
    output logic                            tlp_valid,
    output hc_pkg::tlp_rd_t                 tlp
);

    localparam int AW = hc_pkg::ADDR_W;
    localparam int BW = hc_pkg::BURST_W;
    localparam int LW = hc_pkg::LEN_W;
    localparam int PAGE_BITS = $clog2(hc_pkg::PAGE_LINES);

    typedef enum logic {IDLE, SPLIT} state_t;

    state_t          state;
    logic [AW-1:0]   cur_addr;
    logic [BW-1:0]   lines_left;
    logic [BW-1:0]   page_room;
    logic [BW-1:0]   len_cap;
    logic [BW-1:0]   len_next;
    logic            last_tlp;
    logic            accept;
    logic [AW-1:0]   tlp_last_addr;

    // ==================================================
    // next TLP size
    // ==================================================

    always_comb
    begin
        // lines between the current address and the next 4 KB boundary
        page_room = BW'(hc_pkg::PAGE_LINES) - BW'(cur_addr[PAGE_BITS-1:0]);
        // payload limit first, then whatever the burst still needs
        len_cap = (page_room < BW'(hc_pkg::MAX_PAYLOAD_LINES)) ?
                  page_room : BW'(hc_pkg::MAX_PAYLOAD_LINES);
        len_next = (lines_left < len_cap) ? lines_left : len_cap;
        last_tlp = (lines_left == len_next);
    end

    // the counter sees the size even while idle, it only matters in SPLIT
    assign alloc_len = LW'(len_next);

    // the AFU may only hand over a new burst while nothing is being split
    assign rd_waitrequest = (state != IDLE);
    assign accept = rd_read && !rd_waitrequest;

    // a TLP goes out on every cycle that credit covers its length
    assign alloc = (state == SPLIT) && alloc_ok;
    assign tlp_valid = alloc;

    always_comb
    begin
        tlp.addr = cur_addr;
        tlp.len = alloc_len;
        tlp.rob_idx = alloc_idx;
    end

    // ==================================================
    // state and walk through the burst
    // ==================================================

    always_ff @(posedge afu_clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            lines_left <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        state <= SPLIT;
                        lines_left <= rd_req.burstcount;
                    end
                end
                SPLIT:
                begin
                    if (alloc)
                    begin
                        lines_left <= lines_left - len_next;
                        // leave once the final piece has gone out
                        if (last_tlp)
                        begin
                            state <= IDLE;
                        end
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address of the next piece, loaded at acceptance
    always_ff @(posedge afu_clk)
    begin
        if (accept)
        begin
            cur_addr <= rd_req.addr;
        end
        else if (alloc)
        begin
            cur_addr <= cur_addr + AW'(len_next);
        end
    end

    // last line covered by the TLP on the bus
    assign tlp_last_addr = tlp.addr + AW'(tlp.len) - AW'(1);

    // every issued piece carries between one line and the payload limit
    a_len_range: assert property (@(posedge afu_clk) disable iff (rst)
        tlp_valid |-> (tlp.len >= LW'(1)) && (tlp.len <= LW'(hc_pkg::MAX_PAYLOAD_LINES)));

    // first and last line of a piece sit in the same 4 KB page
    a_no_page_cross: assert property (@(posedge afu_clk) disable iff (rst)
        tlp_valid |-> (tlp_last_addr[AW-1:PAGE_BITS] == tlp.addr[AW-1:PAGE_BITS]));

endmodule

`default_nettype wire

// File: hc_pkg.sv
// host read bridge shared definitions
// widths, page and payload limits, and the request, TLP and completion records
`default_nettype none

package hc_pkg;

    // ==================================================
    // widths and limits
    // ==================================================

    // line address width, one line is 64 bytes
    localparam int ADDR_W = 32;

    // data carried per line on the AFU response side
    localparam int DATA_W = 64;

    // AFU burstcount width, so a burst is 1 to 64 lines
    localparam int BURST_W = 7;

    // TLP length field, in lines
    localparam int LEN_W = 3;

    // a 4 KB page holds 64 lines
    localparam int PAGE_LINES = 64;

    // largest read TLP is 256 bytes
    localparam int MAX_PAYLOAD_LINES = 4;

    // wide enough for the deepest ROB that the top level may ask for
    localparam int ROB_IDX_W = 5;

    // ==================================================
    // records
    // ==================================================

    // one AFU read burst as it arrives on the request side
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [BURST_W-1:0] burstcount;
    } rd_req_t;

    // one host read request
    // rob_idx names the slot of the first line, the rest follow in sequence
    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic [LEN_W-1:0]     len;
        logic [ROB_IDX_W-1:0] rob_idx;
    } tlp_rd_t;

    // one completion line coming back from the host, tagged with its slot
    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [DATA_W-1:0]    data;
    } cpl_t;

endpackage

`default_nettype wire

// File: host_rd_bridge.sv
// host memory read bridge
// AFU read bursts become page-safe TLP reads, completions return in request order
`timescale 1ns/1ns
`default_nettype none

module host_rd_bridge
#(
    // number of ROB lines, a power of two from 8 to 32
    parameter int ROB_DEPTH = 16
)
(
    input  logic                            afu_clk,
    input  logic                            rst,

    // AFU read request side
    input  logic                            rd_read,
    input  hc_pkg::rd_req_t                 rd_req,
    output logic                            rd_waitrequest,

    // AFU read response side
    output logic                            rd_readdatavalid,
    output logic [hc_pkg::DATA_W-1:0]       rd_readdata,

    // host request side
    output logic                            tlp_valid,
    output hc_pkg::tlp_rd_t                 tlp,

    // host completion side, lines arrive in any order
    input  logic                            cpl_valid,
    input  hc_pkg::cpl_t                    cpl
);

    // ==================================================
    // credit loop between the splitter, counter and ROB
    // ==================================================

    logic                            alloc_ok;
    logic [hc_pkg::ROB_IDX_W-1:0]    alloc_idx;
    logic [hc_pkg::LEN_W-1:0]        alloc_len;
    logic                            alloc;
    logic                            release_line;

    // splits each burst and stalls the AFU until its last piece is out
    burst_split_fsm u_split
    (
        .afu_clk        (afu_clk),
        .rst            (rst),
        .rd_read        (rd_read),
        .rd_req         (rd_req),
        .rd_waitrequest (rd_waitrequest),
        .alloc_ok       (alloc_ok),
        .alloc_idx      (alloc_idx),
        .alloc_len      (alloc_len),
        .alloc          (alloc),
        .tlp_valid      (tlp_valid),
        .tlp            (tlp)
    );

    // slot numbering and free-line credit
    rob_alloc_counter #(
        .ROB_DEPTH      (ROB_DEPTH)
    ) u_alloc
    (
        .afu_clk        (afu_clk),
        .rst            (rst),
        .alloc          (alloc),
        .alloc_len      (alloc_len),
        .release_line   (release_line),
        .alloc_ok       (alloc_ok),
        .alloc_idx      (alloc_idx)
    );

    // sorts completions back into request order
    rob_buffer #(
        .ROB_DEPTH      (ROB_DEPTH)
    ) u_rob
    (
        .afu_clk          (afu_clk),
        .rst              (rst),
        .cpl_valid        (cpl_valid),
        .cpl              (cpl),
        .rd_readdatavalid (rd_readdatavalid),
        .rd_readdata      (rd_readdata),
        .release_line     (release_line)
    );

endmodule

`default_nettype wire

// File: rob_alloc_counter.sv
// ROB index allocator
// hands out slot indices per TLP and tracks free ROB lines as read credit
`timescale 1ns/1ns
`default_nettype none

module rob_alloc_counter
#(
    parameter int ROB_DEPTH = 16
)
(
    input  logic                            afu_clk,
    input  logic                            rst,
    input  logic                            alloc,
    input  logic [hc_pkg::LEN_W-1:0]        alloc_len,
    input  logic                            release_line,
    output logic                            alloc_ok,
    output logic [hc_pkg::ROB_IDX_W-1:0]    alloc_idx
);

    localparam int IDX_BITS = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // next slot to hand out, wraps at ROB_DEPTH since the depth is a power of two
    logic [IDX_BITS-1:0] alloc_ptr;
    // lines neither allocated nor in flight
    logic [CNT_W-1:0]    free_cnt;
    logic [CNT_W-1:0]    free_take;
    logic [CNT_W-1:0]    free_give;

    // the whole TLP must fit, a partial grant would split its slot run
    assign alloc_ok = (free_cnt >= CNT_W'(alloc_len));
    assign alloc_idx = hc_pkg::ROB_IDX_W'(alloc_ptr);

    // both can happen in one cycle, the net change is applied at once
    assign free_take = alloc ? CNT_W'(alloc_len) : '0;
    assign free_give = release_line ? CNT_W'(1) : '0;

    always_ff @(posedge afu_clk)
    begin
        if (rst)
        begin
            alloc_ptr <= '0;
            free_cnt <= CNT_W'(ROB_DEPTH);
        end
        else
        begin
            if (alloc)
            begin
                alloc_ptr <= alloc_ptr + IDX_BITS'(alloc_len);
            end
            free_cnt <= free_cnt - free_take + free_give;
        end
    end

    // the splitter must wait for credit before it issues
    a_alloc_has_credit: assert property (@(posedge afu_clk) disable iff (rst)
        alloc |-> alloc_ok);

    // releases never outnumber the lines handed out
    a_free_bounded: assert property (@(posedge afu_clk) disable iff (rst)
        free_cnt <= CNT_W'(ROB_DEPTH));

endmodule

`default_nettype wire

// File: rob_buffer.sv
// reorder buffer for host read completions
// takes lines by slot index in any order and hands them to the AFU in slot order
`timescale 1ns/1ns
`default_nettype none

module rob_buffer
#(
    parameter int ROB_DEPTH = 16
)
(
    input  logic                            afu_clk,
    input  logic                            rst,

    // completions from the host, one line per strobe
    input  logic                            cpl_valid,
    input  hc_pkg::cpl_t                    cpl,

    // in-order responses to the AFU
    output logic                            rd_readdatavalid,
    output logic [hc_pkg::DATA_W-1:0]       rd_readdata,

    // one pulse per line handed out, returns credit to the allocator
    output logic                            release_line
);

    localparam int IDX_BITS = $clog2(ROB_DEPTH);

    // ==================================================
    // storage
    // ==================================================

    logic [hc_pkg::DATA_W-1:0] line_mem [ROB_DEPTH];
    // a set bit means the slot holds data the AFU has not seen yet
    logic [ROB_DEPTH-1:0]      slot_valid;
    // oldest outstanding slot, the only one allowed to leave
    logic [IDX_BITS-1:0]       head;
    logic [IDX_BITS-1:0]       cpl_slot;
    logic                      head_ready;

    // only the low index bits select a slot since slot numbers wrap at the ROB depth
    assign cpl_slot = cpl.rob_idx[IDX_BITS-1:0];

    // completion data lands in the slot named by its index
    always_ff @(posedge afu_clk)
    begin
        if (cpl_valid)
        begin
            line_mem[cpl_slot] <= cpl.data;
        end
    end

    // ==================================================
    // in-order release
    // ==================================================

    // a line written to the head slot goes out on the following cycle
    assign head_ready = slot_valid[head];

    // the AFU cannot stall, so the head line is presented and retired together
    assign rd_readdatavalid = head_ready;
    assign rd_readdata = line_mem[head];
    assign release_line = head_ready;

    always_ff @(posedge afu_clk)
    begin
        if (rst)
        begin
            slot_valid <= '0;
            head <= '0;
        end
        else
        begin
            if (head_ready)
            begin
                slot_valid[head] <= 1'b0;
                head <= head + IDX_BITS'(1);
            end
            // a new completion marks its slot as holding data
            if (cpl_valid)
            begin
                slot_valid[cpl_slot] <= 1'b1;
            end
        end
    end

    // the allocator never reuses a slot before the AFU has taken its line,
    // so the host can never land on one that is still occupied
    a_no_overwrite: assert property (@(posedge afu_clk) disable iff (rst)
        cpl_valid |-> !slot_valid[cpl_slot]);

endmodule

`default_nettype wire

// File: sim.f
hc_pkg.sv
burst_split_fsm.sv
rob_alloc_counter.sv
rob_buffer.sv
host_rd_bridge.sv
tb_host_model.sv
tb_host_rd_bridge.sv

// File: tb_host_model.sv
// host memory model for the read bridge testbench
// queues every requested line and returns them one per cycle in random order
`timescale 1ns/1ns
`default_nettype none

module tb_host_model
(
    input  logic            afu_clk,
    input  logic            rst,
    input  logic            tlp_valid,
    input  hc_pkg::tlp_rd_t tlp,
    output logic            cpl_valid,
    output hc_pkg::cpl_t    cpl
);

    localparam logic [hc_pkg::DATA_W-1:0] XOR_KEY = 64'h5a5a_0000_a5a5_0000;

    // one entry per line still owed to the bridge
    logic [hc_pkg::ADDR_W-1:0]    line_addr_q [$];
    logic [hc_pkg::ROB_IDX_W-1:0] line_idx_q [$];
    integer                       seed;
    integer                       pick;

    initial
    begin
        seed = 32'he0829287;
        cpl_valid = 1'b0;
        cpl = '0;
    end

    // requests are taken mid-cycle, where the bridge outputs have settled
    always @(negedge afu_clk)
    begin
        if (!rst && tlp_valid)
        begin
            // each line of a TLP takes the next slot after the first one
            for (logic [hc_pkg::LEN_W-1:0] k = '0; k < tlp.len; k++)
            begin
                line_addr_q.push_back(tlp.addr + hc_pkg::ADDR_W'(k));
                line_idx_q.push_back(tlp.rob_idx + hc_pkg::ROB_IDX_W'(k));
            end
        end
    end

    // any queued line may come back next, the bridge has to sort them
    always @(posedge afu_clk)
    begin
        if (rst)
        begin
            cpl_valid <= 1'b0;
            line_addr_q.delete();
            line_idx_q.delete();
        end
        else if (line_addr_q.size() != 0)
        begin
            pick = $unsigned($random(seed)) % line_addr_q.size();
            cpl_valid <= 1'b1;
            cpl.rob_idx <= line_idx_q[pick];
            cpl.data <= hc_pkg::DATA_W'(line_addr_q[pick]) ^ XOR_KEY;
            line_addr_q.delete(pick);
            line_idx_q.delete(pick);
        end
        else
        begin
            cpl_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tb_host_rd_bridge.sv
// testbench for the host memory read bridge
// applies a burst table and checks the TLP split, ROB credit and in-order data
`timescale 1ns/1ns
`default_nettype none

module tb_host_rd_bridge;

    localparam int ROB_DEPTH = 16;
    localparam int NUM_ROWS = 8;
    localparam int WAIT_LIMIT = 4000;
    localparam logic [63:0] XOR_KEY = 64'h5a5a_0000_a5a5_0000;

    logic                      afu_clk;
    logic                      rst;
    logic                      rd_read;
    hc_pkg::rd_req_t           rd_req;
    logic                      rd_waitrequest;
    logic                      rd_readdatavalid;
    logic [hc_pkg::DATA_W-1:0] rd_readdata;
    logic                      tlp_valid;
    hc_pkg::tlp_rd_t           tlp;
    logic                      cpl_valid;
    hc_pkg::cpl_t              cpl;

    // burst table, and the TLPs and data lines still expected from it
    hc_pkg::rd_req_t           stim_table [NUM_ROWS];
    logic [hc_pkg::ADDR_W-1:0] exp_tlp_addr_q [$];
    int                        exp_tlp_len_q [$];
    logic [63:0]               exp_data_q [$];
    int                        exp_rob_idx;
    // length the split rule gives for the TLP now on the bus
    int                        next_len;
    // lines issued to the host and not yet handed to the AFU
    int                        in_flight;

    initial
    begin
        afu_clk = 1'b0;
    end

    always #20 afu_clk = ~afu_clk;

    host_rd_bridge #(
        .ROB_DEPTH        (ROB_DEPTH)
    ) DUT
    (
        .afu_clk          (afu_clk),
        .rst              (rst),
        .rd_read          (rd_read),
        .rd_req           (rd_req),
        .rd_waitrequest   (rd_waitrequest),
        .rd_readdatavalid (rd_readdatavalid),
        .rd_readdata      (rd_readdata),
        .tlp_valid        (tlp_valid),
        .tlp              (tlp),
        .cpl_valid        (cpl_valid),
        .cpl              (cpl)
    );

    tb_host_model u_host
    (
        .afu_clk   (afu_clk),
        .rst       (rst),
        .tlp_valid (tlp_valid),
        .tlp       (tlp),
        .cpl_valid (cpl_valid),
        .cpl       (cpl)
    );

    // ==================================================
    // reporting
    // ==================================================

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            stop_with_error($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                                      $time, name, expected, actual));
        end
    endtask

    // ==================================================
    // expected values from the split and XOR rules
    // ==================================================

    task automatic expect_burst(input hc_pkg::rd_req_t req);
        logic [hc_pkg::ADDR_W-1:0] addr;
        int left;
        int room;
        int len;
        addr = req.addr;
        left = int'(req.burstcount);
        while (left > 0)
        begin
            // a piece stops at the payload limit and at the page end
            room = hc_pkg::PAGE_LINES - int'(addr % hc_pkg::PAGE_LINES);
            len = left;
            if (len > hc_pkg::MAX_PAYLOAD_LINES)
            begin
                len = hc_pkg::MAX_PAYLOAD_LINES;
            end
            if (len > room)
            begin
                len = room;
            end
            exp_tlp_addr_q.push_back(addr);
            exp_tlp_len_q.push_back(len);
            addr = addr + hc_pkg::ADDR_W'(len);
            left = left - len;
        end
        // data returns in address order whatever the host does
        for (int i = 0; i < int'(req.burstcount); i++)
        begin
            exp_data_q.push_back(64'(req.addr + hc_pkg::ADDR_W'(i)) ^ XOR_KEY);
        end
    endtask

    // holds the request until the bridge takes it, then drops rd_read
    task automatic send_burst(input hc_pkg::rd_req_t req);
        int waited;
        waited = 0;
        expect_burst(req);
        @(posedge afu_clk);
        rd_read <= 1'b1;
        rd_req <= req;
        @(negedge afu_clk);
        while (rd_waitrequest)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                stop_with_error("timeout: the bridge never accepted a read burst");
            end
            else
            begin
                @(negedge afu_clk);
            end
        end
        @(posedge afu_clk);
        rd_read <= 1'b0;
    endtask

    // ==================================================
    // output monitor sampling mid-cycle
    // ==================================================

    always @(negedge afu_clk)
    begin
        if (!rst)
        begin
            if (tlp_valid)
            begin
                if (exp_tlp_len_q.size() == 0)
                begin
                    stop_with_error("a TLP read request appeared with no burst outstanding");
                end
                else
                begin
                    check_value("tlp.addr", 64'(exp_tlp_addr_q.pop_front()), 64'(tlp.addr));
                    next_len = exp_tlp_len_q.pop_front();
                    check_value("tlp.len", 64'(next_len), 64'(tlp.len));
                    // slots are handed out back to back and wrap at the depth
                    check_value("tlp.rob_idx", 64'(exp_rob_idx), 64'(tlp.rob_idx));
                    exp_rob_idx = (exp_rob_idx + next_len) % ROB_DEPTH;
                    in_flight = in_flight + next_len;
                    if (in_flight > ROB_DEPTH)
                    begin
                        stop_with_error("more lines in flight than the ROB can hold");
                    end
                end
            end
            if (rd_readdatavalid)
            begin
                if (exp_data_q.size() == 0)
                begin
                    stop_with_error("rd_readdatavalid rose with no read line outstanding");
                end
                else
                begin
                    check_value("rd_readdata", exp_data_q.pop_front(), rd_readdata);
                    in_flight--;
                end
            end
        end
    end

    // ==================================================
    // main sequence
    // ==================================================

    initial
    begin
        int waited;
        rst = 1'b1;
        rd_read = 1'b0;
        rd_req = '0;
        exp_rob_idx = 0;
        next_len = 0;
        in_flight = 0;
        waited = 0;

        // three lines inside one page give a single TLP of 3
        stim_table[0] = '{addr: 32'h0000_0105, burstcount: 7'd3};
        // page aligned, split into 4, 4 and 2
        stim_table[1] = '{addr: 32'h0000_0200, burstcount: 7'd10};
        // two lines before a boundary come first, then full pieces
        stim_table[2] = '{addr: 32'h0000_033e, burstcount: 7'd10};
        stim_table[3] = '{addr: 32'h0000_047d, burstcount: 7'd7};
        // back-to-back 32-line bursts need twice the ROB
        stim_table[4] = '{addr: 32'h0000_0580, burstcount: 7'd32};
        stim_table[5] = '{addr: 32'h0000_05a0, burstcount: 7'd32};
        stim_table[6] = '{addr: 32'h0000_0601, burstcount: 7'd64};
        // last line of a page on its own
        stim_table[7] = '{addr: 32'h0000_07ff, burstcount: 7'd1};

        repeat (4) @(posedge afu_clk);
        rst <= 1'b0;

        @(negedge afu_clk);
        check_value("rd_waitrequest", 64'd0, 64'(rd_waitrequest));
        check_value("tlp_valid", 64'd0, 64'(tlp_valid));
        check_value("rd_readdatavalid", 64'd0, 64'(rd_readdatavalid));

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            send_burst(stim_table[r]);
        end

        // the monitor empties the data queue as lines come back
        while (exp_data_q.size() != 0)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                stop_with_error("timeout: read data stopped before all lines returned");
            end
            else
            begin
                @(negedge afu_clk);
            end
        end

        if (exp_tlp_len_q.size() != 0 || in_flight != 0)
        begin
            stop_with_error("TLP requests or lines still outstanding after the data drained");
        end
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
